/* design/gfPkg.sv */
package gfPkg;

	// GF(16) in polynomial basis.
	localparam int gfWidth = 4;
	localparam int codeLength = 15; // n = 2^m - 1.

	typedef logic [gfWidth-1:0] gfElem;

	// x^4 + x + 1 without the leading term.
	localparam gfElem primPoly = 4'b0011;

	// alpha^k with alpha = x, for building constant operands.
	function automatic gfElem alphaPow(input int k);
		gfElem v;
		v = gfElem'(1);
		for (int n = 0; n < k % codeLength; n++)
			v = v[gfWidth-1] ? ((v << 1) ^ primPoly) : (v << 1);
		return v;
	endfunction

endpackage

/* design/bchPkg.sv */
package bchPkg;

	// Bit position, solver step or search step.
	typedef logic [3:0] bitCount;

	// Decoder sequencing.
	typedef enum logic [2:0] {
		stIdle,    // Waiting for the first bit.
		stCollect, // Taking the rest of the word.
		stLoad,    // Solver start from S1.
		stSolve,   // One BM iteration per cycle.
		stSearch   // Chien search and output.
	} decodeState;

endpackage

/* design/decodeCtrlIf.sv */
`timescale 1ns/1ps

interface decodeCtrlIf;

	logic synClear;   // Zero all syndromes.
	logic synShift;   // One received bit.
	logic solveLoad;  // Solver initial state.
	logic solveEn;    // One solver iteration.
	logic searchLoad; // Chien registers from sigma.
	logic searchEn;   // One search step and output bit.

	modport ctrl (
		output synClear, synShift, solveLoad, solveEn, searchLoad, searchEn
	);

	modport dp (
		input synClear, synShift, solveLoad, solveEn, searchLoad, searchEn
	);

endinterface

/* design/gfMultiplier.sv */
`timescale 1ns/1ps

module gfMultiplier import gfPkg::*; (
	input gfElem a,
	input gfElem b,
	output gfElem product
);

	localparam int prodWidth = 2 * gfWidth - 1;

	logic [prodWidth-1:0] acc;

	always_comb begin
		acc = '0;
		// Carry-less partial products.
		for (int i = 0; i < gfWidth; i++)
			if (b[i])
				acc = acc ^ (prodWidth'(a) << i);
		// Fold the high terms back, top bit first.
		for (int k = prodWidth - 1; k >= gfWidth; k--)
			if (acc[k])
				acc = acc ^ (prodWidth'({1'b1, primPoly}) << (k - gfWidth));
	end

	assign product = acc[gfWidth-1:0];

endmodule

/* design/syndromeUnit.sv */
`timescale 1ns/1ps

module syndromeUnit import gfPkg::*; #(
	parameter int T = 3
) (
	input logic clk,
	input logic rst,
	decodeCtrlIf.dp ctrl,
	input logic dataIn,
	output gfElem [2*T-1:0] syndromes // S1 at index 0.
);

	gfElem [2*T-1:0] scaled;

	// S_j times alpha^j, one constant multiplier each.
	for (genvar j = 0; j < 2 * T; j++) begin : genScale
		localparam gfElem alphaJ = alphaPow(j + 1);

		gfMultiplier uMul (
			.a(syndromes[j]),
			.b(alphaJ),
			.product(scaled[j])
		);
	end

	// Horner's rule, highest-degree bit arrives first.
	always_ff @(posedge clk) begin
		if (rst || ctrl.synClear) begin
			syndromes <= '0;
		end else if (ctrl.synShift) begin
			for (int j = 0; j < 2 * T; j++)
				syndromes[j] <= scaled[j] ^ gfElem'(dataIn); // Bit adds into the LSB.
		end
	end

endmodule

/* design/keyEquationSolver.sv */
`timescale 1ns/1ps

module keyEquationSolver import gfPkg::*, bchPkg::*; #(
	parameter int T = 3
) (
	input logic clk,
	input logic rst,
	decodeCtrlIf.dp ctrl,
	input gfElem [2*T-1:0] syndromes,
	input bitCount stepCount,
	output gfElem [T:0] sigma
);

	localparam int bWidth = T * gfWidth;
	localparam int sigWidth = (T + 1) * gfWidth;

	gfElem [T:0] synSel;   // Syndrome paired with each sigma coefficient.
	gfElem [T:0] sigmaSyn;
	gfElem [T:0] dpSigma;
	gfElem [T-1:0] drB;
	gfElem [T-1:0] b;      // Correction polynomial, x^(m-1)·B.
	gfElem [T-1:0] bInit;
	gfElem dr;
	gfElem dp;
	gfElem s1;
	bitCount step;
	bitCount ell;          // Current register length L.
	logic grow;
	logic update;

	assign s1 = syndromes[0];
	assign step = stepCount + 1'b1; // Load already did step 0.
	assign update = ctrl.solveEn && (stepCount < bitCount'(T - 1));

	// S_(2r+1-i) for coefficient i; zero below S1.
	always_comb begin
		int idx;
		for (int i = 0; i <= T; i++) begin
			idx = 2 * int'(step) - i;
			synSel[i] = '0;
			if (idx >= 0 && idx < 2 * T)
				synSel[i] = syndromes[idx];
		end
	end

	for (genvar i = 0; i <= T; i++) begin : genSigmaMul
		gfMultiplier uSyn (.a(sigma[i]), .b(synSel[i]), .product(sigmaSyn[i]));
		gfMultiplier uDp (.a(dp), .b(sigma[i]), .product(dpSigma[i]));
	end

	for (genvar i = 0; i < T; i++) begin : genBMul
		gfMultiplier uDr (.a(dr), .b(b[i]), .product(drB[i]));
	end

	// Discrepancy of the current step.
	always_comb begin
		dr = '0;
		for (int i = 0; i <= T; i++)
			dr = dr ^ sigmaSyn[i];
	end

	assign grow = (dr != '0) && (ell <= step); // Length change.
	assign bInit = (s1 != '0) ? (bWidth'(1) << gfWidth) : (bWidth'(1) << (2 * gfWidth));

	always_ff @(posedge clk) begin
		if (rst)
			ell <= '0;
		else if (ctrl.solveLoad)
			ell <= (s1 != '0) ? bitCount'(1) : bitCount'(0);
		else if (update && grow)
			ell <= bitCount'(2 * step + 1 - ell);
	end

	always_ff @(posedge clk) begin
		if (ctrl.solveLoad) begin
			sigma <= sigWidth'({s1, gfElem'(1)}); // 1 + S1·x.
			b <= bInit;
			dp <= (s1 != '0) ? s1 : gfElem'(1);
		end else if (update) begin
			sigma <= dpSigma ^ {drB, gfElem'(0)}; // dp·sigma + dr·x·b.
			if (grow) begin
				b <= sigma[T-1:0] << gfWidth;
				dp <= dr;
			end else begin
				b <= b << (2 * gfWidth);
			end
		end
	end

endmodule

/* design/chienCorrector.sv */
`timescale 1ns/1ps

module chienCorrector import gfPkg::*, bchPkg::*; #(
	parameter int T = 3
) (
	input logic clk,
	input logic rst,
	decodeCtrlIf.dp ctrl,
	input gfElem [T:0] sigma,
	input logic dataIn,
	output logic outBit,
	output logic outValid,
	output logic uncorrectable
);

	gfElem [T:0] term;
	gfElem [T:0] termIn;
	gfElem [T:0] termNext;
	gfElem evalSum;
	logic [codeLength-1:0] rxBuf; // Received word, r14 at the top.
	logic isRoot;
	logic lastStep;
	bitCount searchIdx;
	bitCount rootCnt;
	bitCount rootTotal;
	bitCount sigmaDeg;
	bitCount degReg;

	// First step starts straight from sigma.
	assign termIn = ctrl.searchLoad ? sigma : term;

	// alpha^(-14i) equals alpha^i, so one constant serves load and step.
	for (genvar i = 0; i <= T; i++) begin : genTerm
		localparam gfElem alphaI = alphaPow(i);

		gfMultiplier uMul (.a(termIn[i]), .b(alphaI), .product(termNext[i]));
	end

	always_comb begin
		evalSum = '0;
		for (int i = 0; i <= T; i++)
			evalSum = evalSum ^ termNext[i];
	end

	always_comb begin
		sigmaDeg = '0;
		for (int i = 1; i <= T; i++)
			if (sigma[i] != '0)
				sigmaDeg = bitCount'(i);
	end

	assign isRoot = (evalSum == '0);
	assign rootTotal = (ctrl.searchLoad ? bitCount'(0) : rootCnt) + bitCount'(isRoot);
	assign lastStep = !ctrl.searchLoad && (searchIdx == bitCount'(codeLength - 1));

	always_ff @(posedge clk) begin
		if (rst) begin
			outValid <= 1'b0;
			uncorrectable <= 1'b0;
			rootCnt <= '0;
			searchIdx <= '0;
		end else begin
			outValid <= ctrl.searchEn;
			// Roots must match the locator degree.
			uncorrectable <= ctrl.searchEn && lastStep && (rootTotal != degReg);
			if (ctrl.searchEn) begin
				rootCnt <= rootTotal;
				searchIdx <= ctrl.searchLoad ? bitCount'(1) : searchIdx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.searchLoad)
			degReg <= sigmaDeg;
		if (ctrl.searchEn) begin
			term <= termNext;
			outBit <= rxBuf[codeLength-1] ^ isRoot; // Flip on a root.
			rxBuf <= {rxBuf[codeLength-2:0], 1'b0};
		end else if (ctrl.synShift) begin
			rxBuf <= {rxBuf[codeLength-2:0], dataIn};
		end
	end

endmodule

/* design/decodeControl.sv */
`timescale 1ns/1ps

module decodeControl import gfPkg::*, bchPkg::*; #(
	parameter int T = 3
) (
	input logic clk,
	input logic rst,
	decodeCtrlIf.ctrl ctrl,
	input logic dataValid,
	output logic ready,
	output bitCount stepCount,
	output logic decodeDone
);

	localparam bitCount lastBit = bitCount'(codeLength - 1);
	localparam bitCount lastSolve = bitCount'(T - 1);

	decodeState state;
	bitCount cnt; // Bits, solver steps or search steps.
	logic accept;

	assign accept = dataValid && ready;
	assign stepCount = cnt;

	always_comb begin
		ctrl.synShift = accept;
		ctrl.synClear = (state == stSearch) && (cnt == lastBit); // Ready for the next word.
		ctrl.solveLoad = (state == stLoad);
		ctrl.solveEn = (state == stSolve);
		ctrl.searchLoad = (state == stSearch) && (cnt == '0);
		ctrl.searchEn = (state == stSearch);
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
			cnt <= '0;
			ready <= 1'b1;
			decodeDone <= 1'b0;
		end else begin
			decodeDone <= 1'b0;
			case (state)
				stIdle: begin
					ready <= 1'b1; // One dead cycle after a word.
					if (accept) begin
						cnt <= bitCount'(1);
						state <= stCollect;
					end
				end
				stCollect: begin
					if (accept) begin
						if (cnt == lastBit) begin
							ready <= 1'b0;
							cnt <= '0;
							state <= stLoad;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end
				end
				stLoad: state <= stSolve;
				stSolve: begin
					if (cnt == lastSolve) begin
						cnt <= '0;
						state <= stSearch;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				stSearch: begin
					if (cnt == lastBit) begin
						cnt <= '0;
						decodeDone <= 1'b1; // Lines up with the last output bit.
						state <= stIdle;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

endmodule

/* design/bchDecoderTop.sv */
`timescale 1ns/1ps

module bchDecoderTop import gfPkg::*, bchPkg::*; #(
	parameter int T = 3
) (
	input logic clk,
	input logic rst,
	input logic dataIn,
	input logic dataValid,
	output logic ready,
	output logic outBit,
	output logic outValid,
	output logic decodeDone,
	output logic uncorrectable
);

	gfElem [2*T-1:0] syndromes;
	gfElem [T:0] sigma;
	bitCount stepCount;

	decodeCtrlIf ctrlBus ();

	decodeControl #(.T(T)) uControl (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrlBus.ctrl),
		.dataValid(dataValid),
		.ready(ready),
		.stepCount(stepCount),
		.decodeDone(decodeDone)
	);

	syndromeUnit #(.T(T)) uSyndrome (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrlBus.dp),
		.dataIn(dataIn),
		.syndromes(syndromes)
	);

	keyEquationSolver #(.T(T)) uSolver (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrlBus.dp),
		.syndromes(syndromes),
		.stepCount(stepCount),
		.sigma(sigma)
	);

	// Buffers the same bits the syndrome unit takes.
	chienCorrector #(.T(T)) uChien (
		.clk(clk),
		.rst(rst),
		.ctrl(ctrlBus.dp),
		.sigma(sigma),
		.dataIn(dataIn),
		.outBit(outBit),
		.outValid(outValid),
		.uncorrectable(uncorrectable)
	);

endmodule

/* verif/tbClock.sv */
`timescale 1ns/1ps

module tbClock #(
	parameter int periodNs = 4
) (
	output logic clk
);

	initial clk = 1'b0;

	// Free-running, first rising edge at half a period.
	always #(periodNs / 2.0) clk = ~clk;

endmodule

/* verif/bchDecoderTb.sv */
`timescale 1ns/1ps

module bchDecoderTb;

	localparam int T = 3;
	localparam int clkPeriod = 4;
	localparam int numWords = 41; // 1 + 15 + 10 + 10 + 5.
	localparam int maxWait = 40;  // Cycles allowed before the first output bit.
	localparam logic [14:0] genPoly = 15'h537; // g(x) of the (15,5) code.

	logic clk;
	logic rst;
	logic dataIn;
	logic dataValid;
	logic ready;
	logic outBit;
	logic outValid;
	logic decodeDone;
	logic uncorrectable;
	integer seed = 89;
	int errCount = 0;
	int checkCount = 0;

	tbClock #(.periodNs(clkPeriod)) uClock (.clk(clk));

	bchDecoderTop #(.T(T)) dut0 (
		.clk(clk),
		.rst(rst),
		.dataIn(dataIn),
		.dataValid(dataValid),
		.ready(ready),
		.outBit(outBit),
		.outValid(outValid),
		.decodeDone(decodeDone),
		.uncorrectable(uncorrectable)
	);

	// Non-systematic codeword as message times g(x).
	function automatic logic [14:0] encode(input logic [4:0] msg);
		logic [14:0] cw;
		cw = '0;
		for (int i = 0; i < 5; i++)
			if (msg[i])
				cw = cw ^ (genPoly << i);
		return cw;
	endfunction

	task automatic expectEqual(input string sigName, input logic [14:0] expVal,
			input logic [14:0] gotVal);
		checkCount++;
		assert (gotVal === expVal) else begin
			errCount++;
			$display("ERR %0t ns %s expected 'h%0h got 'h%0h", $time, sigName, expVal, gotVal);
		end
	endtask

	task automatic noteFailure(input string what);
		errCount++;
		$display("%0t ns: %s", $time, what);
	endtask

	// Random bits on the input while the decoder is busy.
	task automatic driveNoise(input bit noise);
		if (noise) begin
			dataValid = 1'b1;
			dataIn = $random(seed);
		end
	endtask

	// Distinct random error positions.
	task automatic makeErrorMask(input int nErr, output logic [14:0] mask);
		int pos;
		mask = '0;
		while ($countones(mask) < nErr) begin
			pos = $unsigned($random(seed)) % 15;
			mask[pos] = 1'b1;
		end
	endtask

	// Enters and leaves on a falling edge. r14 goes first.
	task automatic sendWord(input logic [14:0] word);
		int waited;
		waited = 0;
		while (!ready && waited < maxWait) begin
			@(negedge clk);
			waited++;
		end
		checkCount++;
		assert (ready) else noteFailure("ready stayed low, word not sent");
		for (int i = 14; i >= 0; i--) begin
			dataValid = 1'b1;
			dataIn = word[i];
			@(negedge clk);
		end
		dataValid = 1'b0;
	endtask

	// Latency is counted in rising edges after the one that took the last bit.
	task automatic collectWord(input bit noise, output logic [14:0] word, output bit ok);
		int edges;
		edges = 0;
		ok = 1'b0;
		word = '0;
		while (!outValid && edges < maxWait) begin
			driveNoise(noise);
			@(negedge clk);
			edges++;
		end
		checkCount++;
		assert (outValid) else begin
			noteFailure("no outValid after the last input bit");
			dataValid = 1'b0;
			return;
		end
		expectEqual("latency", 15'(T + 2), 15'(edges));
		for (int n = 1; n <= 15; n++) begin
			if (n > 1) begin
				checkCount++;
				assert (outValid) else noteFailure("outValid dropped before the 15th output bit");
			end
			word = {word[13:0], outBit};
			if (n < 15) begin
				expectEqual("decodeDone", 1'b0, decodeDone);
				driveNoise(noise);
			end else begin
				checkCount++;
				assert (decodeDone) else noteFailure("decodeDone missing with the 15th output bit");
				expectEqual("uncorrectable", 1'b0, uncorrectable);
				dataValid = 1'b0;
			end
			@(negedge clk);
		end
		expectEqual("outValid", 1'b0, outValid); // Exactly 15 bits.
		expectEqual("ready", 1'b1, ready);
		ok = 1'b1;
	endtask

	task automatic decodeWord(input logic [14:0] codeword, input logic [14:0] errMask,
			input bit noise);
		logic [14:0] got;
		bit ok;
		sendWord(codeword ^ errMask);
		collectWord(noise, got, ok);
		if (ok)
			expectEqual("outWord", codeword, got);
	endtask

	task automatic resetAndCleanWord;
		expectEqual("ready", 1'b1, ready);
		expectEqual("outValid", 1'b0, outValid);
		expectEqual("decodeDone", 1'b0, decodeDone);
		expectEqual("uncorrectable", 1'b0, uncorrectable);
		decodeWord(encode(5'($random(seed))), '0, 1'b0);
	endtask

	task automatic singleErrorSweep;
		for (int pos = 0; pos < 15; pos++)
			decodeWord(encode(5'($random(seed))), 15'(1) << pos, 1'b0);
	endtask

	task automatic multiErrorWords(input int nErr, input int count);
		logic [14:0] mask;
		for (int k = 0; k < count; k++) begin
			makeErrorMask(nErr, mask);
			decodeWord(encode(5'($random(seed))), mask, 1'b0);
		end
	endtask

	// Noise while busy and then words sent as soon as ready returns.
	task automatic busyStrobesAndBackToBack;
		logic [14:0] mask;
		makeErrorMask(2, mask);
		decodeWord(encode(5'($random(seed))), mask, 1'b1);
		for (int k = 0; k < 4; k++) begin
			makeErrorMask(1 + $unsigned($random(seed)) % 3, mask);
			decodeWord(encode(5'($random(seed))), mask, 1'b0);
		end
	endtask

	initial begin
		#((numWords * (15 + T + 20) + 100) * clkPeriod);
		$display("Watchdog expired before all words were decoded");
		$display("Test FAILED");
		$finish;
	end

	initial begin
		rst = 1'b1;
		dataIn = 1'b0;
		dataValid = 1'b0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		resetAndCleanWord();
		singleErrorSweep();
		multiErrorWords(2, 10);
		multiErrorWords(3, 10);
		busyStrobesAndBackToBack();
		$display("Checks: %0d, errors: %0d", checkCount, errCount);
		if (errCount == 0)
			$display("Test OK");
		else
			$display("Test FAILED");
		$finish;
	end

endmodule

/* compile.f */
design/gfPkg.sv
design/bchPkg.sv
design/decodeCtrlIf.sv
design/gfMultiplier.sv
design/syndromeUnit.sv
design/keyEquationSolver.sv
design/chienCorrector.sv
design/decodeControl.sv
design/bchDecoderTop.sv
verif/tbClock.sv
verif/bchDecoderTb.sv
